//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

  // architectural register width
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [6:0]      opcode_t;

  // major opcodes, bits [6:0] of the instruction
  localparam opcode_t op_lui     = 7'b0110111;
  localparam opcode_t op_auipc   = 7'b0010111;
  localparam opcode_t op_jal     = 7'b1101111;
  localparam opcode_t op_jalr    = 7'b1100111;
  localparam opcode_t op_branch  = 7'b1100011;
  localparam opcode_t op_load    = 7'b0000011;
  localparam opcode_t op_store   = 7'b0100011;
  localparam opcode_t op_reg_imm = 7'b0010011;
  localparam opcode_t op_reg_reg = 7'b0110011;
  localparam opcode_t op_environ = 7'b1110011;

  // branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // only word-sized memory accesses are supported
  localparam logic [2:0] f3_word = 3'b010;

  // funct7 that turns add into sub and srl into sra
  localparam logic [6:0] funct7_alt = 7'b0100000;

endpackage

//--- src/core_ctrl_pkg.sv
package core_ctrl_pkg;

  // operation performed by the alu
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  // source of the value written to rd
  typedef enum logic [2:0] {
    wb_alu,
    wb_imm_upper,
    wb_pc_rel_upper,
    wb_pc_plus4,
    wb_load
  } wb_sel_t;

  // how the next pc is formed
  typedef enum logic [1:0] {
    flow_seq,
    flow_branch,
    flow_jal,
    flow_jalr
  } flow_t;

endpackage

//--- src/insn_decoder.sv
module insn_decoder (
  input  rv_isa_pkg::word_t      insn,
  output rv_isa_pkg::reg_idx_t   rs1,
  output rv_isa_pkg::reg_idx_t   rs2,
  output rv_isa_pkg::reg_idx_t   rd,
  output rv_isa_pkg::word_t      imm,
  output core_ctrl_pkg::alu_op_t alu_op,
  output logic                   use_imm,
  output core_ctrl_pkg::wb_sel_t wb_sel,
  output core_ctrl_pkg::flow_t   flow,
  output logic [2:0]             funct3,
  output logic                   rd_we,
  output logic                   is_load,
  output logic                   is_store,
  output logic                   is_ecall
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  opcode_t    opcode;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  logic       alt_f7;
  logic       zero_f7;
  alu_op_t    f3_op;

  // fixed field positions
  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  // sign bit is always insn[31]
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign alt_f7  = (funct7 == funct7_alt);
  assign zero_f7 = (funct7 == 7'd0);

  // alu operation selected by funct3, sub only exists in the reg-reg form
  always_comb begin
    case (funct3)
      3'b000:  f3_op = (alt_f7 && opcode == op_reg_reg) ? alu_sub : alu_add;
      3'b001:  f3_op = alu_sll;
      3'b010:  f3_op = alu_slt;
      3'b011:  f3_op = alu_sltu;
      3'b100:  f3_op = alu_xor;
      3'b101:  f3_op = alt_f7 ? alu_sra : alu_srl;
      3'b110:  f3_op = alu_or;
      default: f3_op = alu_and;
    endcase
  end

  always_comb begin
    // unknown encodings fall through as a no-op
    imm      = imm_i;
    alu_op   = alu_add;
    use_imm  = 1'b0;
    wb_sel   = wb_alu;
    flow     = flow_seq;
    rd_we    = 1'b0;
    is_load  = 1'b0;
    is_store = 1'b0;
    is_ecall = 1'b0;
    case (opcode)
      op_lui: begin
        imm    = imm_u;
        wb_sel = wb_imm_upper;
        rd_we  = 1'b1;
      end
      op_auipc: begin
        imm    = imm_u;
        wb_sel = wb_pc_rel_upper;
        rd_we  = 1'b1;
      end
      op_jal: begin
        imm    = imm_j;
        wb_sel = wb_pc_plus4;
        flow   = flow_jal;
        rd_we  = 1'b1;
      end
      op_jalr: begin
        // target comes from the alu as rs1 + imm
        if (funct3 == 3'b000) begin
          use_imm = 1'b1;
          wb_sel  = wb_pc_plus4;
          flow    = flow_jalr;
          rd_we   = 1'b1;
        end
      end
      op_branch: begin
        imm = imm_b;
        if (funct3 inside {f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu}) begin
          flow = flow_branch;
        end
      end
      op_load: begin
        if (funct3 == f3_word) begin
          use_imm = 1'b1;
          wb_sel  = wb_load;
          rd_we   = 1'b1;
          is_load = 1'b1;
        end
      end
      op_store: begin
        imm = imm_s;
        if (funct3 == f3_word) begin
          use_imm  = 1'b1;
          is_store = 1'b1;
        end
      end
      op_reg_imm: begin
        alu_op  = f3_op;
        use_imm = 1'b1;
        // shifts carry a funct7 in the upper immediate bits
        case (funct3)
          3'b001:  rd_we = zero_f7;
          3'b101:  rd_we = zero_f7 || alt_f7;
          default: rd_we = 1'b1;
        endcase
      end
      op_reg_reg: begin
        alu_op = f3_op;
        rd_we  = zero_f7 || (alt_f7 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      op_environ: begin
        is_ecall = (insn[31:7] == 25'd0);
      end
      default: begin
      end
    endcase
  end

endmodule

//--- src/reg_file.sv
module reg_file (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 we,
  input  rv_isa_pkg::reg_idx_t rd,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  input  rv_isa_pkg::word_t    rd_data,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data
);
  import rv_isa_pkg::*;

  localparam int num_regs = 32;

  word_t regs [num_regs];

  // x0 is never written, so it keeps its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // combinational read ports
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 reads zero on both ports whatever the core tries to write
  a_x0_zero : assert property (
    @(posedge clk) disable iff (rst)
      (rs1 == '0 |-> rs1_data == '0) and (rs2 == '0 |-> rs2_data == '0)
  );

endmodule

//--- src/alu.sv
module alu (
  input  core_ctrl_pkg::alu_op_t alu_op,
  input  logic                   use_imm,
  input  rv_isa_pkg::word_t      a,
  input  rv_isa_pkg::word_t      rs2_data,
  input  rv_isa_pkg::word_t      imm,
  output rv_isa_pkg::word_t      result
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  word_t      b;
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // second operand is either rs2 or the immediate
  assign b     = use_imm ? imm : rs2_data;
  assign shamt = b[4:0];

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (alu_op)
      alu_add: begin
        result = a + b;
      end
      alu_sub: begin
        result = a - b;
      end
      alu_sll: begin
        result = a << shamt;
      end
      alu_slt: begin
        result = {{(xlen - 1){1'b0}}, lt_signed};
      end
      alu_sltu: begin
        result = {{(xlen - 1){1'b0}}, lt_unsigned};
      end
      alu_xor: begin
        result = a ^ b;
      end
      alu_srl: begin
        result = a >> shamt;
      end
      alu_sra: begin
        // arithmetic shift keeps the sign bit
        result = word_t'($signed(a) >>> shamt);
      end
      alu_or: begin
        result = a | b;
      end
      alu_and: begin
        result = a & b;
      end
      default: begin
        result = a + b;
      end
    endcase
  end

endmodule

//--- src/retire_unit.sv
module retire_unit #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_isa_pkg::word_t      rs1_data,
  input  rv_isa_pkg::word_t      rs2_data,
  input  rv_isa_pkg::word_t      imm,
  input  rv_isa_pkg::word_t      result,
  input  rv_isa_pkg::word_t      dmem_rdata,
  input  core_ctrl_pkg::wb_sel_t wb_sel,
  input  core_ctrl_pkg::flow_t   flow,
  input  logic [2:0]             funct3,
  input  logic                   rd_we,
  input  logic                   is_load,
  input  logic                   is_store,
  input  logic                   is_ecall,
  output rv_isa_pkg::word_t      pc,
  output rv_isa_pkg::word_t      rd_data,
  output rv_isa_pkg::word_t      dmem_addr,
  output rv_isa_pkg::word_t      dmem_wdata,
  output logic                   reg_we,
  output logic                   dmem_we,
  output logic                   halt
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  word_t pc_plus4;
  word_t pc_target;
  word_t pc_next;
  logic  taken;

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;

  // branch condition on the two register operands
  always_comb begin
    case (funct3)
      f3_beq:  taken = (rs1_data == rs2_data);
      f3_bne:  taken = (rs1_data != rs2_data);
      f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      f3_bltu: taken = (rs1_data < rs2_data);
      f3_bgeu: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (flow)
      flow_branch: pc_next = taken ? pc_target : pc_plus4;
      flow_jal:    pc_next = pc_target;
      // jalr target is rs1 + imm from the alu, lsb cleared
      flow_jalr:   pc_next = {result[xlen-1:1], 1'b0};
      default:     pc_next = pc_plus4;
    endcase
    // ecall parks the core on itself
    if (is_ecall) begin
      pc_next = pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

  always_comb begin
    case (wb_sel)
      wb_imm_upper:    rd_data = imm;
      wb_pc_rel_upper: rd_data = pc_target;
      wb_pc_plus4:     rd_data = pc_plus4;
      wb_load:         rd_data = dmem_rdata;
      default:         rd_data = result;
    endcase
  end

  // no side effects while in reset or halted
  assign reg_we  = rd_we && !is_ecall && !rst;
  assign dmem_we = is_store && !rst;
  assign halt    = is_ecall;

  // effective address is rs1 + imm, computed by the alu
  assign dmem_addr  = (is_load || is_store) ? result : '0;
  assign dmem_wdata = is_store ? rs2_data : '0;

  a_pc_aligned : assert property (
    @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
  );

  a_dmem_aligned : assert property (
    @(posedge clk) disable iff (rst) (is_load || is_store) |-> dmem_addr[1:0] == 2'b00
  );

endmodule

//--- src/rv_core.sv
module rv_core #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  logic              clk,
  input  logic              rst,
  input  rv_isa_pkg::word_t insn,
  input  rv_isa_pkg::word_t dmem_rdata,
  output rv_isa_pkg::word_t pc,
  output rv_isa_pkg::word_t dmem_addr,
  output rv_isa_pkg::word_t dmem_wdata,
  output logic              dmem_we,
  output logic              halt
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  // decoded fields
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  word_t      imm;
  alu_op_t    alu_op;
  logic       use_imm;
  wb_sel_t    wb_sel;
  flow_t      flow;
  logic [2:0] funct3;
  logic       rd_we;
  logic       is_load;
  logic       is_store;
  logic       is_ecall;

  // datapath
  word_t rs1_data;
  word_t rs2_data;
  word_t result;
  word_t rd_data;
  logic  reg_we;

  insn_decoder decoder_i (
    .insn     (insn),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .imm      (imm),
    .alu_op   (alu_op),
    .use_imm  (use_imm),
    .wb_sel   (wb_sel),
    .flow     (flow),
    .funct3   (funct3),
    .rd_we    (rd_we),
    .is_load  (is_load),
    .is_store (is_store),
    .is_ecall (is_ecall)
  );

  reg_file reg_file_i (
    .clk      (clk),
    .rst      (rst),
    .we       (reg_we),
    .rd       (rd),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu alu_i (
    .alu_op   (alu_op),
    .use_imm  (use_imm),
    .a        (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .result   (result)
  );

  retire_unit #(
    .reset_pc (reset_pc)
  ) retire_i (
    .clk        (clk),
    .rst        (rst),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .result     (result),
    .dmem_rdata (dmem_rdata),
    .wb_sel     (wb_sel),
    .flow       (flow),
    .funct3     (funct3),
    .rd_we      (rd_we),
    .is_load    (is_load),
    .is_store   (is_store),
    .is_ecall   (is_ecall),
    .pc         (pc),
    .rd_data    (rd_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .reg_we     (reg_we),
    .dmem_we    (dmem_we),
    .halt       (halt)
  );

endmodule

//--- tb/rv_ref_model.svh
// model state of the core plus the memory access of the last step
typedef struct packed {
  word_t [31:0]           regs;
  word_t [dmem_words-1:0] mem;
  word_t                  pc;
  logic                   st_we;
  word_t                  m_addr;
  word_t                  m_wdata;
  logic                   halt;
} model_t;

function automatic word_t ref_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3:    return (a < b) ? 32'd1 : 32'd0;
    3'd4:    return a ^ b;
    3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

// executes one instruction on the model state
function automatic model_t ref_step(model_t s, word_t ins);
  model_t     n;
  word_t      a;
  word_t      b;
  word_t      res;
  word_t      addr;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  logic [2:0] f3;
  logic       alt;
  logic       wr;
  logic       taken;
  reg_idx_t   rd;
  n = s;
  n.st_we = 1'b0;
  n.m_addr = '0;
  n.m_wdata = '0;
  n.halt = 1'b0;
  a = s.regs[ins[19:15]];
  b = s.regs[ins[24:20]];
  f3 = ins[14:12];
  rd = ins[11:7];
  alt = (ins[31:25] == 7'b0100000);
  imm_i = {{20{ins[31]}}, ins[31:20]};
  imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
  imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
  imm_u = {ins[31:12], 12'd0};
  n.pc = s.pc + 32'd4;
  res = '0;
  wr = 1'b0;
  taken = 1'b0;
  case (ins[6:0])
    7'b0110111: begin
      res = imm_u;
      wr = 1'b1;
    end
    7'b0010111: begin
      res = s.pc + imm_u;
      wr = 1'b1;
    end
    7'b1101111: begin
      res = s.pc + 32'd4;
      wr = 1'b1;
      n.pc = s.pc + imm_j;
    end
    7'b1100111: begin
      res = s.pc + 32'd4;
      wr = 1'b1;
      n.pc = (a + imm_i) & ~32'd1;
    end
    7'b1100011: begin
      case (f3)
        3'd0:    taken = (a == b);
        3'd1:    taken = (a != b);
        3'd4:    taken = ($signed(a) < $signed(b));
        3'd5:    taken = ($signed(a) >= $signed(b));
        3'd6:    taken = (a < b);
        3'd7:    taken = (a >= b);
        default: taken = 1'b0;
      endcase
      if (taken) begin
        n.pc = s.pc + imm_b;
      end
    end
    7'b0000011: begin
      addr = a + imm_i;
      n.m_addr = addr;
      res = s.mem[addr[7:2]];
      wr = 1'b1;
    end
    7'b0100011: begin
      addr = a + imm_s;
      n.st_we = 1'b1;
      n.m_addr = addr;
      n.m_wdata = b;
      n.mem[addr[7:2]] = b;
    end
    7'b0010011: begin
      res = ref_alu(f3, alt && f3 == 3'd5, a, imm_i);
      wr = 1'b1;
    end
    7'b0110011: begin
      res = ref_alu(f3, alt, a, b);
      wr = 1'b1;
    end
    7'b1110011: begin
      // ecall holds the pc
      if (ins[31:7] == 25'd0) begin
        n.halt = 1'b1;
        n.pc = s.pc;
      end
    end
    default: begin
    end
  endcase
  if (wr && rd != 5'd0) begin
    n.regs[rd] = res;
  end
  return n;
endfunction

//--- tb/rv_core_tb.sv
module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_isa_pkg::*;

  localparam int imem_words   = 512;
  localparam int dmem_words   = 64;
  localparam int halt_timeout = 2000;

  logic  clk;
  logic  rst;
  word_t insn;
  word_t dmem_rdata;
  word_t pc;
  word_t dmem_addr;
  word_t dmem_wdata;
  logic  dmem_we;
  logic  halt;

  word_t imem [imem_words];
  word_t dmem [dmem_words];
  int    n_insn;
  int    slot;
  int    mismatches = 0;
  int    failures = 0;

  `include "rv_ref_model.svh"

  model_t model;
  model_t nxt;

  rv_core #(
    .reset_pc ('0)
  ) dut_i (
    .clk        (clk),
    .rst        (rst),
    .insn       (insn),
    .dmem_rdata (dmem_rdata),
    .pc         (pc),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .halt       (halt)
  );

  // both memories answer in the same cycle
  assign insn       = imem[pc[10:2]];
  assign dmem_rdata = dmem[dmem_addr[7:2]];

  always @(posedge clk) begin
    if (!rst && dmem_we) begin
      dmem[dmem_addr[7:2]] <= dmem_wdata;
    end
  end

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  function automatic word_t fill_word(int i);
    return (word_t'(i) * 32'h01000193) ^ 32'h6a09e667;
  endfunction

  function automatic model_t model_reset();
    model_t s;
    s = '0;
    for (int i = 0; i < dmem_words; i++) begin
      s.mem[i] = fill_word(i);
    end
    return s;
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                  reg_idx_t rd, opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg_reg};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, f3_word, imm[4:0], op_store};
  endfunction

  function automatic word_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_j(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  function automatic reg_idx_t rand_reg();
    return reg_idx_t'(1 + $urandom % 15);
  endfunction

  task automatic emit(word_t w);
    imem[n_insn] = w;
    n_insn++;
  endtask

  // x17 counts the branches that fall through
  task automatic branch_over(reg_idx_t rs1, reg_idx_t rs2, logic [2:0] f3);
    emit(enc_b(13'd8, rs2, rs1, f3));
    emit(enc_i(12'd1, 5'd17, 3'd0, 5'd17, op_reg_imm));
  endtask

  // each store goes to the next data word
  task automatic store_reg(reg_idx_t r);
    emit(enc_s(12'(slot * 4), r, 5'd0));
    slot = (slot + 1) % dmem_words;
  endtask

  task automatic build_program();
    reg_idx_t    rd;
    reg_idx_t    ra;
    reg_idx_t    rb;
    logic [2:0]  f3;
    logic [11:0] imm;
    int          sel;
    n_insn = 0;
    slot = 0;
    for (int r = 1; r < 16; r++) begin
      emit(enc_u(20'($urandom), reg_idx_t'(r), op_lui));
      emit(enc_i(12'($urandom), reg_idx_t'(r), 3'd0, reg_idx_t'(r), op_reg_imm));
    end
    // the add into x0 is dropped and x0 stores zero
    emit(enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd0));
    store_reg(5'd0);
    // x16 is negative as a signed value and large as an unsigned one
    emit(enc_u(20'h80000, 5'd16, op_lui));
    emit(enc_i(12'h5a3, 5'd16, 3'd0, 5'd16, op_reg_imm));
    // each branch condition with equal operands and with x16 against x0 both ways
    for (int i = 0; i < 6; i++) begin
      f3 = 3'((i < 2) ? i : i + 2);
      branch_over(5'd0, 5'd0, f3);
      branch_over(5'd16, 5'd0, f3);
      branch_over(5'd0, 5'd16, f3);
    end
    store_reg(5'd17);
    // every alu operation in both operand forms
    for (int i = 0; i < 8; i++) begin
      emit(enc_i(12'h013, 5'd16, 3'(i), 5'd18, op_reg_imm));
      store_reg(5'd18);
      emit(enc_r(7'd0, 5'd1, 5'd16, 3'(i), 5'd18));
      store_reg(5'd18);
    end
    emit(enc_i(12'h413, 5'd16, 3'd5, 5'd18, op_reg_imm));
    store_reg(5'd18);
    emit(enc_r(funct7_alt, 5'd1, 5'd16, 3'd0, 5'd18));
    store_reg(5'd18);
    emit(enc_r(funct7_alt, 5'd1, 5'd16, 3'd5, 5'd18));
    store_reg(5'd18);
    for (int k = 0; k < 40; k++) begin
      rd = rand_reg();
      ra = rand_reg();
      rb = rand_reg();
      f3 = 3'($urandom);
      sel = $urandom % 6;
      case (sel)
        0: begin
          imm = 12'($urandom);
          // shift amounts need a legal funct7 above them
          if (f3 == 3'd1) imm[11:5] = 7'd0;
          if (f3 == 3'd5) imm[11:5] = {1'b0, imm[10], 5'd0};
          emit(enc_i(imm, ra, f3, rd, op_reg_imm));
        end
        1: begin
          emit(enc_r(((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 1)) ? funct7_alt : 7'd0,
                     rb, ra, f3, rd));
        end
        2: emit(enc_u(20'($urandom), rd, op_auipc));
        // reads back a word that an earlier store wrote
        3: emit(enc_i(12'(($urandom % slot) * 4), 5'd0, f3_word, rd, op_load));
        4: begin
          // forward branch over one addi with equal operands now and then
          sel = $urandom % 6;
          f3 = 3'((sel < 2) ? sel : sel + 2);
          emit(enc_b(13'd8, ($urandom % 4 == 0) ? ra : rb, ra, f3));
          emit(enc_i(12'd1, rd, 3'd0, rd, op_reg_imm));
        end
        default: begin
          if ($urandom % 2 == 1) begin
            emit(enc_j(21'd8, rd));
          end else begin
            // odd offset whose bit 0 the core clears
            emit(enc_u(20'd0, ra, op_auipc));
            emit(enc_i(12'd13, ra, 3'd0, rd, op_jalr));
          end
          emit(enc_i(12'd1, rd, 3'd0, rd, op_reg_imm));
        end
      endcase
      store_reg(rd);
    end
    emit(enc_i(12'd0, 5'd0, 3'd0, 5'd0, op_environ));
  endtask

  // compares mid-cycle and keeps going after halt so the parked state is checked too
  always @(negedge clk) begin
    if (rst) begin
      model = model_reset();
    end else begin
      check_word("pc", pc, model.pc);
      nxt = ref_step(model, imem[model.pc[10:2]]);
      check_flag("dmem_we", dmem_we, nxt.st_we);
      check_word("dmem_addr", dmem_addr, nxt.m_addr);
      check_word("dmem_wdata", dmem_wdata, nxt.m_wdata);
      check_flag("halt", halt, nxt.halt);
      model = nxt;
    end
  end

  initial begin
    int cycles;
    rst = 1'b1;
    void'($urandom(4));
    for (int i = 0; i < imem_words; i++) begin
      imem[i] = enc_i(12'd0, 5'd0, 3'd0, 5'd0, op_environ);
    end
    for (int i = 0; i < dmem_words; i++) begin
      dmem[i] = fill_word(i);
    end
    build_program();
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    cycles = 0;
    while (halt !== 1'b1 && cycles < halt_timeout) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (halt !== 1'b1) begin
      $display("timeout: core did not halt within %0d cycles", halt_timeout);
      failures++;
    end
    // five more cycles parked on the ecall
    repeat (5) @(posedge clk);
    #1;
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+tb
src/rv_isa_pkg.sv
src/core_ctrl_pkg.sv
src/insn_decoder.sv
src/reg_file.sv
src/alu.sv
src/retire_unit.sv
src/rv_core.sv
tb/rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the core testbench with verilator, run it, check the log
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tb.f --top-module rv_core_tb -Mdir "$build_dir" -o rv_core_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/rv_core_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test OK" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
